/* hw/vic_clock_phase.sv */
`timescale 1ns/1ps

module vic_clock_phase
   import vic_pkg::*;
(
   input  logic clk_dot4x,
   input  logic rst,
   output logic clk_phi,
   output logic dot_rising_0,
   output logic phi_phase_start_0
);

   // position within the phi cycle, 0 to PHI_PERIOD-1
   logic [PHASE_W-1:0] phase_cnt;
   logic [PHASE_W-1:0] phase_nxt;

   assign phase_nxt = phase_cnt + 1'b1;

   // strobes decode the next count, so they line up with phase_cnt
   // and come straight from flops
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase_cnt         <= '0;
         dot_rising_0      <= 1'b1;
         phi_phase_start_0 <= 1'b1;
      end else begin
         phase_cnt <= phase_nxt;
         // one dot every 4 ticks
         dot_rising_0 <= (phase_nxt[1:0] == 2'd0);
         // start of each phi half
         phi_phase_start_0 <= (phase_nxt[PHASE_W-2:0] == '0);
      end
   end

   // low for the first half, high for the second
   assign clk_phi = phase_cnt[PHASE_W-1];

endmodule

/* hw/vic_cycle_counter.sv */
`timescale 1ns/1ps

module vic_cycle_counter
   import vic_pkg::*;
(
   input  logic         clk_dot4x,
   input  logic         rst,
   input  logic         clk_phi,
   input  logic         phi_phase_start_0,
   input  chip_timing_t timing,
   output logic [6:0]   cycle_num
);

   logic [6:0] cycle_q;
   logic [6:0] cycle_inc;
   logic       phi_wrap;
   logic [6:0] last_cycle;

   assign last_cycle = timing.cycles_per_line - 7'd1;

   // first tick of the low half, the phase counter has just wrapped
   assign phi_wrap = phi_phase_start_0 & ~clk_phi;

   assign cycle_inc = (cycle_q == last_cycle) ? 7'd0 : cycle_q + 7'd1;

   // cycle_q catches up one tick after the wrap
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         // parked on the last cycle, so the first tick out of reset shows 0
         cycle_q <= last_cycle;
      end else if (phi_wrap) begin
         cycle_q <= cycle_inc;
      end
   end

   // new number already visible in the wrap tick itself,
   // in step with raster_x reaching the next group of 8 dots
   assign cycle_num = phi_wrap ? cycle_inc : cycle_q;

endmodule

/* hw/vic_pkg.sv */
package vic_pkg;

   // chip model select
   // the unused code behaves like the 6569
   typedef enum logic [1:0] {
      chip_6567r56a = 2'd0,
      chip_6567r8   = 2'd1,
      chip_6569     = 2'd2,
      chip_unused   = 2'd3
   } chip_t;

   // line geometry of one chip model
   typedef struct packed {
      logic [6:0] cycles_per_line;
      logic [9:0] raster_x_max;
      logic [8:0] raster_y_max;
   } chip_timing_t;

   // clk_dot4x cycles per phi cycle, and the phase counter width
   localparam int PHI_PERIOD = 32;
   localparam int PHASE_W    = $clog2(PHI_PERIOD);

   // xpos reload at the line wrap
   localparam logic [9:0] XPOS_START_NTSC = 10'h19c;
   localparam logic [9:0] XPOS_START_PAL  = 10'h194;

   // xpos taken at cycle 0, bit 0
   localparam logic [9:0] XPOS_CYC0_NTSC = 10'h19d;
   localparam logic [9:0] XPOS_CYC0_PAL  = 10'h195;

   // the 6567R8 repeats this xpos around cycles 60 and 61
   localparam logic [9:0] XPOS_R8_HOLD = 10'h184;

   // sprite_raster_x start, line length minus 55 or 54 cycles of 8 dots
   localparam logic [9:0] SPRITE_X_OFFSET_R8    = 10'd80;
   localparam logic [9:0] SPRITE_X_OFFSET_OTHER = 10'd72;

   function automatic chip_timing_t chip_timing(chip_t chip);
      chip_timing_t t;
      case (chip)
         chip_6567r56a: begin
            t.cycles_per_line = 7'd64;
            t.raster_y_max    = 9'd261;
         end
         chip_6567r8: begin
            t.cycles_per_line = 7'd65;
            t.raster_y_max    = 9'd262;
         end
         default: begin
            t.cycles_per_line = 7'd63;
            t.raster_y_max    = 9'd311;
         end
      endcase
      // 8 dots per cycle, last dot of the line
      t.raster_x_max = {t.cycles_per_line - 7'd1, 3'b111};
      return t;
   endfunction

endpackage

/* hw/vic_raster.sv */
`timescale 1ns/1ps

module vic_raster
   import vic_pkg::*;
(
   input  logic         clk_dot4x,
   input  logic         rst,
   input  logic         clk_phi,
   input  logic         phi_phase_start_0,
   input  logic         dot_rising_0,
   input  chip_t        chip,
   input  logic [6:0]   cycle_num,
   input  chip_timing_t timing,
   output logic [9:0]   xpos,
   output logic [9:0]   raster_x,
   output logic [9:0]   sprite_raster_x,
   output logic [8:0]   raster_line,
   output logic [8:0]   raster_line_d
);

   // pending update of raster_line_d after a line or frame wrap
   logic       start_of_line;
   logic       start_of_frame;

   // dot number within the phi cycle, valid at the dot strobe
   logic [2:0] cycle_bit;

   logic       ntsc;
   logic       r8_hold;
   logic       line_wrap;
   logic       sprite_wrap;
   logic [9:0] xpos_start;
   logic [9:0] xpos_cyc0;
   logic [9:0] sprite_x_start;
   logic [9:0] xpos_step;

   assign cycle_bit = raster_x[2:0];

   assign ntsc = (chip == chip_6567r56a) || (chip == chip_6567r8);

   assign xpos_start = ntsc ? XPOS_START_NTSC : XPOS_START_PAL;
   assign xpos_cyc0  = ntsc ? XPOS_CYC0_NTSC : XPOS_CYC0_PAL;

   // sprite #0 fetch window opens at sprite_raster_x == 0
   assign sprite_x_start = (chip == chip_6567r8) ? SPRITE_X_OFFSET_R8 : SPRITE_X_OFFSET_OTHER;

   assign line_wrap   = (raster_x >= timing.raster_x_max);
   assign sprite_wrap = (sprite_raster_x >= timing.raster_x_max);

   // the 6567R8 stalls xpos for a few dots near the end of the line
   always_comb begin
      r8_hold = 1'b0;
      if (chip == chip_6567r8) begin
         if (cycle_num == 7'd60 && cycle_bit == 3'd7)
            r8_hold = 1'b1;
         else if (cycle_num == 7'd61 && (cycle_bit == 3'd3 || cycle_bit == 3'd7))
            r8_hold = 1'b1;
      end
   end

   // next xpos inside the line
   always_comb begin
      if (cycle_num == 7'd0 && cycle_bit == 3'd0)
         xpos_step = xpos_cyc0;
      else if (r8_hold)
         xpos_step = XPOS_R8_HOLD;
      else if (cycle_num == 7'd12 && cycle_bit == 3'd3)
         xpos_step = 10'd0;
      else
         xpos_step = xpos + 10'd1;
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x        <= '0;
         raster_line     <= '0;
         raster_line_d   <= '0;
         start_of_line   <= 1'b0;
         start_of_frame  <= 1'b0;
         xpos            <= xpos_start;
         sprite_raster_x <= sprite_x_start;
      end else begin
         // delayed line copy moves at the start of the high phi half
         if (clk_phi && phi_phase_start_0) begin
            if (start_of_line) begin
               raster_line_d <= raster_line;
               start_of_line <= 1'b0;
            end else if (start_of_frame && cycle_num == 7'd1) begin
               // new frame is seen one cycle later
               raster_line_d  <= raster_line;
               start_of_frame <= 1'b0;
            end
         end

         if (dot_rising_0) begin
            if (line_wrap) begin
               raster_x <= '0;
               xpos     <= xpos_start;
               if (raster_line >= timing.raster_y_max) begin
                  raster_line    <= '0;
                  start_of_frame <= 1'b1;
               end else begin
                  raster_line   <= raster_line + 9'd1;
                  start_of_line <= 1'b1;
               end
            end else begin
               raster_x <= raster_x + 10'd1;
               xpos     <= xpos_step;
            end

            // same line length, shifted start
            if (sprite_wrap)
               sprite_raster_x <= '0;
            else
               sprite_raster_x <= sprite_raster_x + 10'd1;
         end
      end
   end

endmodule

/* hw/vic_raster_irq.sv */
`timescale 1ns/1ps

module vic_raster_irq (
   input  logic       clk_dot4x,
   input  logic       rst,
   input  logic [8:0] raster_line,
   input  logic [8:0] raster_compare,
   input  logic       irq_ack,
   output logic       irq
);

   // line seen last tick, a difference marks a new line
   logic [8:0] line_q;
   logic       line_changed;
   logic       line_match;

   assign line_changed = (raster_line != line_q);

   // only the entry into the compare line counts,
   // staying on it does not re-raise after an acknowledge
   assign line_match = line_changed && (raster_line == raster_compare);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         line_q <= '0;
         irq    <= 1'b0;
      end else begin
         line_q <= raster_line;
         // a fresh match beats an acknowledge in the same tick
         if (line_match)
            irq <= 1'b1;
         else if (irq_ack)
            irq <= 1'b0;
      end
   end

endmodule

/* hw/vic_raster_top.sv */
`timescale 1ns/1ps

module vic_raster_top
   import vic_pkg::*;
(
   input  logic       clk_dot4x,
   input  logic       rst,
   input  chip_t      chip,
   input  logic [8:0] raster_compare,
   input  logic       irq_ack,
   output logic [9:0] xpos,
   output logic [9:0] raster_x,
   output logic [9:0] sprite_raster_x,
   output logic [8:0] raster_line,
   output logic [8:0] raster_line_d,
   output logic [6:0] cycle_num,
   output logic       irq
);

   // chip is static outside reset, so the lookup is plain logic
   chip_timing_t timing;

   logic clk_phi;
   logic dot_rising_0;
   logic phi_phase_start_0;

   assign timing = chip_timing(chip);

   vic_clock_phase u_clock_phase (
      .clk_dot4x         (clk_dot4x),
      .rst               (rst),
      .clk_phi           (clk_phi),
      .dot_rising_0      (dot_rising_0),
      .phi_phase_start_0 (phi_phase_start_0)
   );

   vic_cycle_counter u_cycle (
      .clk_dot4x         (clk_dot4x),
      .rst               (rst),
      .clk_phi           (clk_phi),
      .phi_phase_start_0 (phi_phase_start_0),
      .timing            (timing),
      .cycle_num         (cycle_num)
   );

   vic_raster u_raster (
      .clk_dot4x         (clk_dot4x),
      .rst               (rst),
      .clk_phi           (clk_phi),
      .phi_phase_start_0 (phi_phase_start_0),
      .dot_rising_0      (dot_rising_0),
      .chip              (chip),
      .cycle_num         (cycle_num),
      .timing            (timing),
      .xpos              (xpos),
      .raster_x          (raster_x),
      .sprite_raster_x   (sprite_raster_x),
      .raster_line       (raster_line),
      .raster_line_d     (raster_line_d)
   );

   vic_raster_irq u_irq (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .raster_line    (raster_line),
      .raster_compare (raster_compare),
      .irq_ack        (irq_ack),
      .irq            (irq)
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_vic_raster \
   -f vic_raster.f -o vsim_vic_raster &&
./obj_dir/vsim_vic_raster +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation finished: PASS$" sim.log && echo "run_sim: passed" && exit 0 ||
   { echo "run_sim: failed"; exit 1; }

/* sim/vic_raster_tests.svh */
`ifndef VIC_RASTER_TESTS_SVH
`define VIC_RASTER_TESTS_SVH

   // runs every chip code including the unused one
   task automatic test_reset_values();
      int    start;
      int    i;
      chip_t c;
      start = errors;
      for (i = 0; i < 4; i++) begin
         c = chip_t'(i);
         reset_dut(c, NO_MATCH_LINE);
         check_value("raster_x", 0, raster_x);
         check_value("raster_line", 0, raster_line);
         check_value("raster_line_d", 0, raster_line_d);
         check_value("cycle_num", 0, cycle_num);
         check_value("xpos", is_ntsc(c) ? XPOS_START_NTSC : XPOS_START_PAL, xpos);
         check_value("sprite_raster_x",
                     (c == chip_6567r8) ? SPRITE_X_OFFSET_R8 : SPRITE_X_OFFSET_OTHER,
                     sprite_raster_x);
         check_value("irq", 0, irq);
      end
      report_test("reset values", start);
   endtask

   task automatic test_line_positions();
      int start;
      int i;
      start = errors;
      for (i = 0; i < 4; i++) begin
         reset_dut(chip_t'(i), NO_MATCH_LINE);
         compare_outputs();
         // two lines and a few dots into the third
         run_and_compare(2 * m_cycles * PHI_PERIOD + 40);
      end
      report_test("line positions", start);
   endtask

   // dot number and cycle number seen at each dot strobe
   task automatic test_cycle_alignment();
      int start;
      int i;
      start = errors;
      for (i = 0; i < 4; i++) begin
         reset_dut(chip_t'(i), NO_MATCH_LINE);
         repeat (2 * m_cycles * PHI_PERIOD) begin
            run_cycle(1'b0);
            if (t % 4 == 0) begin
               check_value("raster_x[2:0]", (t / 4) % 8, raster_x[2:0]);
               // first dot of each line in the model
               if (m_rx == 0) begin
                  check_value("raster_x at line start", 0, raster_x);
                  check_value("cycle_num at raster_x 0", 0, cycle_num);
               end
            end
         end
      end
      report_test("cycle alignment", start);
   endtask

   task automatic test_frame();
      int start;
      int i;
      int frame_len;
      start = errors;
      for (i = 0; i < 3; i++) begin
         reset_dut(chip_t'(i), NO_MATCH_LINE);
         frame_len = (m_y_max + 1) * m_cycles * PHI_PERIOD;
         // up to the last phi cycle of the frame
         run_and_compare(frame_len - PHI_PERIOD);
         check_value("raster_line at frame end", m_y_max, raster_line);
         // across the wrap and past cycle 2 of the new frame
         run_and_compare(4 * PHI_PERIOD);
         check_value("raster_line after wrap", 0, raster_line);
      end
      report_test("full frame", start);
   endtask

   task automatic test_raster_irq();
      int start;
      int cmp;
      start = errors;
      cmp   = $urandom_range(last_line_for(chip_6567r56a), 1);
      reset_dut(chip_6567r56a, cmp[8:0]);
      while (m_line != cmp)
         run_and_compare(1);
      run_and_compare(1);
      check_value("irq on compare line", 1, irq);
      run_and_compare(200);
      check_value("irq held until ack", 1, irq);
      run_cycle(1'b1);
      compare_outputs();
      run_cycle(1'b0);
      compare_outputs();
      check_value("irq after ack", 0, irq);
      // the following lines must not raise it again
      run_and_compare(2 * m_cycles * PHI_PERIOD);
      report_test("raster irq", start);
   endtask

`endif

/* sim/tb_vic_raster.sv */
`timescale 1ns/1ps

module tb_vic_raster
   import vic_pkg::*;
();

   localparam int CLK_HALF     = 50;
   localparam int RESET_CYCLES = 10;
   // three frames of at most 63 * 32 * 312 = 628992 ticks, the irq run of up to
   // one 6567R56A frame, the short tests and a margin
   localparam int TIMEOUT_CYCLES = 2_500_000;
   localparam int MAX_ERRORS     = 50;
   // above the last line of every chip
   localparam logic [8:0] NO_MATCH_LINE = 9'h1ff;

   logic       clk_dot4x;
   logic       rst;
   chip_t      chip;
   logic [8:0] raster_compare;
   logic       irq_ack;
   logic [9:0] xpos;
   logic [9:0] raster_x;
   logic [9:0] sprite_raster_x;
   logic [8:0] raster_line;
   logic [8:0] raster_line_d;
   logic [6:0] cycle_num;
   logic       irq;

   int errors      = 0;
   int checks      = 0;
   int cycle_count = 0;

   // reference model state where t counts ticks since reset release
   int    t;
   chip_t m_chip;
   int    m_cycles;
   int    m_rx_max;
   int    m_y_max;
   int    m_start;
   int    m_cyc0;
   int    m_rx;
   int    m_xpos;
   int    m_sx;
   int    m_line;
   int    m_line_prev;
   logic  m_irq;

   vic_raster_top u_dut (
      .clk_dot4x       (clk_dot4x),
      .rst             (rst),
      .chip            (chip),
      .raster_compare  (raster_compare),
      .irq_ack         (irq_ack),
      .xpos            (xpos),
      .raster_x        (raster_x),
      .sprite_raster_x (sprite_raster_x),
      .raster_line     (raster_line),
      .raster_line_d   (raster_line_d),
      .cycle_num       (cycle_num),
      .irq             (irq)
   );

   initial clk_dot4x = 1'b0;
   always #(CLK_HALF) clk_dot4x = ~clk_dot4x;

   always @(posedge clk_dot4x) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   function automatic int cycles_for(chip_t c);
      case (c)
         chip_6567r56a: return 64;
         chip_6567r8:   return 65;
         default:       return 63;
      endcase
   endfunction

   function automatic int last_line_for(chip_t c);
      case (c)
         chip_6567r56a: return 261;
         chip_6567r8:   return 262;
         default:       return 311;
      endcase
   endfunction

   function automatic logic is_ntsc(chip_t c);
      return (c == chip_6567r56a) || (c == chip_6567r8);
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic model_reset(input chip_t c);
      m_chip      = c;
      m_cycles    = cycles_for(c);
      m_rx_max    = m_cycles * 8 - 1;
      m_y_max     = last_line_for(c);
      m_start     = is_ntsc(c) ? XPOS_START_NTSC : XPOS_START_PAL;
      m_cyc0      = is_ntsc(c) ? XPOS_CYC0_NTSC : XPOS_CYC0_PAL;
      m_sx        = (c == chip_6567r8) ? SPRITE_X_OFFSET_R8 : SPRITE_X_OFFSET_OTHER;
      m_rx        = 0;
      m_xpos      = m_start;
      m_line      = 0;
      m_line_prev = 0;
      m_irq       = 1'b0;
      t           = 0;
   endtask

   // state change at the edge that ends tick t
   task automatic model_clock_edge();
      int   cyc;
      int   dot_bit;
      logic hold;
      cyc     = (t / PHI_PERIOD) % m_cycles;
      dot_bit = m_rx % 8;
      hold    = (m_chip == chip_6567r8) &&
                ((cyc == 60 && dot_bit == 7) || (cyc == 61 && (dot_bit == 3 || dot_bit == 7)));
      if (m_line != m_line_prev && m_line == int'(raster_compare))
         m_irq = 1'b1;
      else if (irq_ack)
         m_irq = 1'b0;
      m_line_prev = m_line;
      if (t % 4 == 0) begin
         if (m_rx >= m_rx_max) begin
            m_rx   = 0;
            m_xpos = m_start;
            m_line = (m_line >= m_y_max) ? 0 : m_line + 1;
         end else begin
            m_rx = m_rx + 1;
            if (cyc == 0 && dot_bit == 0)
               m_xpos = m_cyc0;
            else if (cyc == 12 && dot_bit == 3)
               m_xpos = 0;
            else if (hold)
               m_xpos = XPOS_R8_HOLD;
            else
               m_xpos = (m_xpos + 1) % 1024;
         end
         m_sx = (m_sx >= m_rx_max) ? 0 : m_sx + 1;
      end
      t++;
   endtask

   task automatic reset_dut(input chip_t c, input logic [8:0] cmp);
      @(posedge clk_dot4x);
      rst            <= 1'b1;
      chip           <= c;
      raster_compare <= cmp;
      irq_ack        <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_dot4x);
      rst <= 1'b0;
      @(negedge clk_dot4x);
      model_reset(c);
   endtask

   // one tick where ack takes effect at the following edge
   task automatic run_cycle(input logic ack);
      @(posedge clk_dot4x);
      model_clock_edge();
      irq_ack <= ack;
      @(negedge clk_dot4x);
   endtask

   task automatic compare_outputs();
      int cyc;
      cyc = (t / PHI_PERIOD) % m_cycles;
      check_value("raster_x", m_rx, raster_x);
      check_value("xpos", m_xpos, xpos);
      check_value("sprite_raster_x", m_sx, sprite_raster_x);
      check_value("raster_line", m_line, raster_line);
      check_value("cycle_num", cyc, cycle_num);
      check_value("irq", m_irq, irq);
      if (cyc == 2)
         check_value("raster_line_d", m_line, raster_line_d);
   endtask

   task automatic run_and_compare(input int n);
      repeat (n) begin
         run_cycle(1'b0);
         // stop comparing once the error limit is hit
         if (errors < MAX_ERRORS)
            compare_outputs();
      end
   endtask

   task automatic report_test(input string name, input int start_errors);
      if (errors == start_errors)
         $display("Test %s: ok", name);
      else
         $display("Test %s: %0d errors", name, errors - start_errors);
   endtask

   `include "vic_raster_tests.svh"

   initial begin
      rst            = 1'b1;
      chip           = chip_6569;
      raster_compare = NO_MATCH_LINE;
      irq_ack        = 1'b0;
      void'($urandom(79812));
      test_reset_values();
      test_line_positions();
      test_cycle_alignment();
      test_frame();
      test_raster_irq();
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, u_dut.u_props.fail_count);
      if (errors == 0 && u_dut.u_props.fail_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* sim/vic_raster_props.sv */
`timescale 1ns/1ps

module vic_raster_props
   import vic_pkg::*;
(
   input logic         clk_dot4x,
   input logic         rst,
   input logic         dot_rising_0,
   input logic         clk_phi,
   input chip_timing_t timing,
   input logic [9:0]   raster_x,
   input logic [8:0]   raster_line,
   input logic [8:0]   raster_compare,
   input logic         irq_ack,
   input logic         irq
);

   // ticks since reset, same as the position inside the phi cycle
   logic [4:0] tick;

   // read by the testbench at the end of the run
   int fail_count = 0;

   always_ff @(posedge clk_dot4x) begin
      if (rst)
         tick <= '0;
      else
         tick <= tick + 5'd1;
   end

   a_dot_period: assert property (@(posedge clk_dot4x) disable iff (rst)
      dot_rising_0 == (tick[1:0] == 2'd0))
      else begin
         fail_count++;
         $error("dot strobe is off the 4-tick grid");
      end

   a_phi_half: assert property (@(posedge clk_dot4x) disable iff (rst)
      (clk_phi != $past(clk_phi)) |-> (tick[3:0] == 4'd0))
      else begin
         fail_count++;
         $error("clk_phi changed inside a 16-tick half");
      end

   a_raster_x_max: assert property (@(posedge clk_dot4x) disable iff (rst)
      raster_x <= timing.raster_x_max)
      else begin
         fail_count++;
         $error("raster_x beyond the last dot of the line");
      end

   // a fresh line match in the ack tick keeps irq set
   a_irq_ack: assert property (@(posedge clk_dot4x) disable iff (rst)
      (irq_ack && !(raster_line != $past(raster_line) && raster_line == raster_compare))
      |=> !irq)
      else begin
         fail_count++;
         $error("irq still set after acknowledge");
      end

endmodule

bind vic_raster_top vic_raster_props u_props (
   .clk_dot4x      (clk_dot4x),
   .rst            (rst),
   .dot_rising_0   (dot_rising_0),
   .clk_phi        (clk_phi),
   .timing         (timing),
   .raster_x       (raster_x),
   .raster_line    (raster_line),
   .raster_compare (raster_compare),
   .irq_ack        (irq_ack),
   .irq            (irq)
);

/* vic_raster.f */
+incdir+sim
hw/vic_pkg.sv
hw/vic_clock_phase.sv
hw/vic_cycle_counter.sv
hw/vic_raster.sv
hw/vic_raster_irq.sv
hw/vic_raster_top.sv
sim/vic_raster_props.sv
sim/tb_vic_raster.sv
